// ==== Makefile ====
# Verilator build, run and lint of the memory system testbench

VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -j 0
LINTFLAGS := --lint-only --timing --assert -Wall
TOP       := MemSysTb
FILELIST  := memSys.f
BUILD_DIR := obj_dir
SOURCES   := $(wildcard rtl/*.sv rtl/*.svh verif/*.sv)

.PHONY: all run lint clean

all: run

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== memSys.f ====
+incdir+rtl
rtl/MemSysTypes.sv
rtl/ResetController.sv
rtl/ProgramLoader.sv
rtl/LatencyPipe.sv
rtl/Memory.sv
rtl/MemSysTop.sv
verif/MemSysTb.sv

// ==== rtl/LatencyPipe.sv ====
// Latency pipe
// Fixed-depth shift pipe for response payloads, one stage per cycle,
// so a new payload can enter on every clock

`timescale 1ns/1ps
`default_nettype none

module LatencyPipe #(
    parameter type T     = logic [7:0],
    parameter int  DEPTH = 2
) (
    input  logic clk,
    input  logic arstN,
    input  logic rst,
    input  T     in,
    output T     out
);

    T stage [DEPTH];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;  // Clears the valid field as well
            end
        end else if (rst) begin
            for (int i = 0; i < DEPTH; i++) begin
                stage[i] <= '0;
            end
        end else begin
            stage[0] <= in;
            for (int i = 1; i < DEPTH; i++) begin
                stage[i] <= stage[i-1];
            end
        end
    end

    assign out = stage[DEPTH-1];

endmodule : LatencyPipe

`default_nettype wire

// ==== rtl/MemSysTop.sv ====
// Memory system top level
// Reset controller, program loader and internal memory. The loader
// owns the memory port until loading is done, the core port after that

`timescale 1ns/1ps
`default_nettype none

module MemSysTop (
    input  logic                        clk,
    input  logic                        arstN,
    input  MemSysTypes::LoaderWrite     hostLoad,
    input  logic                        hostDone,
    input  MemSysTypes::MemAccessReq    coreReq,
    output MemSysTypes::MemReadResp     readResp,
    output MemSysTypes::MemWriteResp    writeResp,
    output MemSysTypes::MemAccessSerial nextMemReadSerial,
    output MemSysTypes::MemWriteSerial  nextMemWriteSerial,
    output logic                        programLoaded,
    output logic                        rstStart
);

    import MemSysTypes::*;

    logic        rst;     // Stretched reset
    MemAccessReq memReq;  // Selected request into the RAM

    ResetController rstController (
        .clk      (clk),
        .arstN    (arstN),
        .rst      (rst),
        .rstStart (rstStart)
    );

    ProgramLoader programLoader (
        .clk           (clk),
        .arstN         (arstN),
        .rst           (rst),
        .rstStart      (rstStart),
        .hostLoad      (hostLoad),
        .hostDone      (hostDone),
        .coreReq       (coreReq),
        .memReq        (memReq),
        .programLoaded (programLoaded)
    );

    Memory memory (
        .clk                (clk),
        .arstN              (arstN),
        .rst                (rst),
        .memReq             (memReq),
        .readResp           (readResp),
        .writeResp          (writeResp),
        .nextMemReadSerial  (nextMemReadSerial),
        .nextMemWriteSerial (nextMemWriteSerial)
    );

endmodule : MemSysTop

`default_nettype wire

// ==== rtl/MemSysTypes.sv ====
// Memory system types
// Path types and the request, response and host load structs
// shared by the loader, the memory and the top level

`default_nettype none

`include "memSys_params.svh"

package MemSysTypes;

    // Basic paths
    typedef logic [`MEM_ADDR_WIDTH-1:0] AddrPath;
    typedef logic [`MEM_DATA_WIDTH-1:0] MemoryEntryDataPath;

    // Serials handed out to requests
    typedef logic [`MEM_SERIAL_WIDTH-1:0] MemAccessSerial;  // Reads
    typedef logic [`MEM_SERIAL_WIDTH-1:0] MemWriteSerial;   // Writes

    // One request on the memory port, re and we are exclusive
    typedef struct packed {
        logic               re;
        logic               we;
        AddrPath            addr;
        MemoryEntryDataPath writeData;
    } MemAccessReq;

    // Read data coming back after the read latency
    typedef struct packed {
        logic               valid;
        MemAccessSerial     serial;
        MemoryEntryDataPath data;
    } MemReadResp;

    // Write completion
    typedef struct packed {
        logic          valid;
        MemWriteSerial serial;
    } MemWriteResp;

    // One beat from the host while the program is loaded
    typedef struct packed {
        logic               we;
        AddrPath            addr;
        MemoryEntryDataPath data;
    } LoaderWrite;

endpackage : MemSysTypes

`default_nettype wire

// ==== rtl/Memory.sv ====
// Internal memory
// Single-port RAM with fixed read and write latencies. Every accepted
// request takes the next serial of its kind, which returns with the response

`timescale 1ns/1ps
`default_nettype none

`include "memSys_params.svh"

module Memory (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        rst,
    input  MemSysTypes::MemAccessReq    memReq,
    output MemSysTypes::MemReadResp     readResp,
    output MemSysTypes::MemWriteResp    writeResp,
    output MemSysTypes::MemAccessSerial nextMemReadSerial,
    output MemSysTypes::MemWriteSerial  nextMemWriteSerial
);

    import MemSysTypes::*;

    MemoryEntryDataPath ram [`MEM_ENTRY_NUM];
    MemoryEntryDataPath ramReadData;

    logic readAccept;
    logic writeAccept;
    logic readIssued;   // First cycle of each response
    logic writeIssued;

    MemAccessSerial readSerialQ;
    MemWriteSerial  writeSerialQ;

    MemReadResp  readStage;
    MemWriteResp writeStage;

    // Nothing is accepted while reset is held
    assign readAccept  = memReq.re && !rst;
    assign writeAccept = memReq.we && !rst;

    // RAM and response payloads
    // Read sees the entry before any write on the same edge
    always_ff @(posedge clk) begin
        if (writeAccept) begin
            ram[memReq.addr] <= memReq.writeData;
        end
        ramReadData  <= ram[memReq.addr];
        readSerialQ  <= nextMemReadSerial;
        writeSerialQ <= nextMemWriteSerial;
    end

    // Serial counters and issue flags
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            nextMemReadSerial  <= '0;
            nextMemWriteSerial <= '0;
            readIssued         <= 1'b0;
            writeIssued        <= 1'b0;
        end else if (rst) begin
            nextMemReadSerial  <= '0;
            nextMemWriteSerial <= '0;
            readIssued         <= 1'b0;
            writeIssued        <= 1'b0;
        end else begin
            readIssued  <= readAccept;
            writeIssued <= writeAccept;
            if (readAccept) begin
                nextMemReadSerial <= nextMemReadSerial + 1'b1;   // Wraps at 16
            end
            if (writeAccept) begin
                nextMemWriteSerial <= nextMemWriteSerial + 1'b1;
            end
        end
    end

    always_comb begin
        readStage.valid  = readIssued;
        readStage.serial = readSerialQ;
        readStage.data   = ramReadData;
        writeStage.valid  = writeIssued;
        writeStage.serial = writeSerialQ;
    end

    // The registered stage above gives the first cycle of each latency
    LatencyPipe #(
        .T     (MemReadResp),
        .DEPTH (`MEM_READ_LATENCY - 1)
    ) readPipe (
        .clk   (clk),
        .arstN (arstN),
        .rst   (rst),
        .in    (readStage),
        .out   (readResp)
    );

    LatencyPipe #(
        .T     (MemWriteResp),
        .DEPTH (`MEM_WRITE_LATENCY - 1)
    ) writePipe (
        .clk   (clk),
        .arstN (arstN),
        .rst   (rst),
        .in    (writeStage),
        .out   (writeResp)
    );

    assert property (@(posedge clk) disable iff (rst)
        !(memReq.re && memReq.we))
        else $error("Memory: re and we set in the same cycle");

    // Every read comes back after the read latency with the serial it was given
    assert property (@(posedge clk) disable iff (rst)
        readAccept |-> ##(`MEM_READ_LATENCY)
            (readResp.valid && readResp.serial == $past(nextMemReadSerial, `MEM_READ_LATENCY)))
        else $error("Memory: read response missing or serial out of order");

endmodule : Memory

`default_nettype wire

// ==== rtl/ProgramLoader.sv ====
// Program loader
// Keeps the loaded flag and steers the memory port: host load beats
// become writes until loading is done, then the core owns the port

`timescale 1ns/1ps
`default_nettype none

module ProgramLoader (
    input  logic                     clk,
    input  logic                     arstN,
    input  logic                     rst,
    input  logic                     rstStart,
    input  MemSysTypes::LoaderWrite  hostLoad,
    input  logic                     hostDone,
    input  MemSysTypes::MemAccessReq coreReq,
    output MemSysTypes::MemAccessReq memReq,
    output logic                     programLoaded
);

    // Loaded state
    // Cleared through reset and once more by the start pulse, so beats
    // seen before reset ends do not finish the load
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            programLoaded <= 1'b0;
        end else if (rst || rstStart) begin
            programLoaded <= 1'b0;
        end else if (hostDone) begin
            programLoaded <= 1'b1;
        end
    end

    // Port select, no added latency
    always_comb begin
        if (!programLoaded) begin
            memReq.re        = 1'b0;          // Host only writes
            memReq.we        = hostLoad.we;
            memReq.addr      = hostLoad.addr;
            memReq.writeData = hostLoad.data;
        end else begin
            memReq = coreReq;                 // Core request passes unchanged
        end
    end

    // Host beats after loading are dropped by the select above
    assert property (@(posedge clk) disable iff (rst)
        programLoaded |-> !hostLoad.we)
        else $warning("ProgramLoader: host write ignored after program load");

    // Core may never read and write in the same cycle
    assert property (@(posedge clk) disable iff (rst)
        !(coreReq.re && coreReq.we))
        else $error("ProgramLoader: coreReq sets re and we together");

endmodule : ProgramLoader

`default_nettype wire

// ==== rtl/ResetController.sv ====
// Reset controller
// Holds rst for a fixed number of edges after arstN is released,
// then pulses rstStart for the first cycle out of reset

`timescale 1ns/1ps
`default_nettype none

`include "memSys_params.svh"

module ResetController (
    input  logic clk,
    input  logic arstN,
    output logic rst,
    output logic rstStart
);

    localparam int HOLD_CNT_WIDTH = $clog2(`RST_HOLD_CYCLES);

    logic [HOLD_CNT_WIDTH-1:0] holdCnt;
    logic                      holdDone;

    // Last edge of the hold window
    assign holdDone = (holdCnt == HOLD_CNT_WIDTH'(`RST_HOLD_CYCLES - 1));

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            holdCnt  <= '0;
            rst      <= 1'b1;
            rstStart <= 1'b0;
        end else begin
            rstStart <= rst && holdDone;  // Rises together with rst falling
            if (rst) begin
                if (holdDone) begin
                    rst <= 1'b0;
                end else begin
                    holdCnt <= holdCnt + 1'b1;
                end
            end
        end
    end

    // The start pulse belongs to the first cycle after the hold window
    assert property (@(posedge clk) disable iff (!arstN)
        rstStart |-> (!rst && $past(rst)))
        else $error("ResetController: rstStart outside the reset release cycle");

endmodule : ResetController

`default_nettype wire

// ==== rtl/memSys_params.svh ====
// Memory system parameters
// Widths, RAM depth, access latencies and reset stretch length

`ifndef MEM_SYS_PARAMS_SVH
`define MEM_SYS_PARAMS_SVH

// Entry address and data
`define MEM_ADDR_WIDTH 8
`define MEM_DATA_WIDTH 64

// Number of RAM entries
`define MEM_ENTRY_NUM (1 << `MEM_ADDR_WIDTH)

// Request tags, wrap modulo 16
`define MEM_SERIAL_WIDTH 4

// Cycles from an accepted request to its response
`define MEM_READ_LATENCY 3
`define MEM_WRITE_LATENCY 2

// Clock edges that reset is held after arstN is released
`define RST_HOLD_CYCLES 16

`endif

// ==== verif/MemSysTb.sv ====
// Memory system testbench
// Plays the host and the core, keeps a reference copy of the RAM
// and checks every read and write response against it

`timescale 1ns/1ps
`default_nettype none

`include "memSys_params.svh"

module MemSysTb;

    import MemSysTypes::*;

    localparam int CLK_PERIOD   = 8;
    localparam int RESET_CYCLES = 8;
    localparam int EARLY_OPS    = 20;
    localparam int RANDOM_OPS   = 400;
    localparam int HOST_BEATS   = 8;

    // Cycles per test, each with room to drain
    localparam int RESET_LEN    = RESET_CYCLES + `RST_HOLD_CYCLES + 8;
    localparam int EARLY_LEN    = EARLY_OPS + 10;
    localparam int LOAD_LEN     = `MEM_ENTRY_NUM + 10;
    localparam int READBACK_LEN = `MEM_ENTRY_NUM + 8;
    localparam int RANDOM_LEN   = RANDOM_OPS + 8;
    localparam int HOST_LEN     = 2 * HOST_BEATS + 8;
    localparam int WATCHDOG_CYCLES = RESET_LEN + EARLY_LEN + LOAD_LEN + READBACK_LEN
                                   + RANDOM_LEN + HOST_LEN + 200;

    typedef struct packed {
        int                 due;     // Cycle count when the response shows
        MemAccessSerial     serial;
        MemoryEntryDataPath data;
    } ExpectedRead;

    typedef struct packed {
        int            due;
        MemWriteSerial serial;
    } ExpectedWrite;

    logic           clk = 1'b0;
    logic           arstN;
    LoaderWrite     hostLoad;
    logic           hostDone;
    MemAccessReq    coreReq;
    MemReadResp     readResp;
    MemWriteResp    writeResp;
    MemAccessSerial nextMemReadSerial;
    MemWriteSerial  nextMemWriteSerial;
    logic           programLoaded;
    logic           rstStart;

    MemoryEntryDataPath model [`MEM_ENTRY_NUM];  // Reference RAM
    ExpectedRead        readExp [$];
    ExpectedWrite       writeExp [$];
    MemAccessSerial     readSerial  = '0;        // Serials the next requests must get
    MemWriteSerial      writeSerial = '0;
    int                 cycle       = 0;
    int                 rstPulses   = 0;
    string              testName    = "reset";

    MemSysTop dut0 (
        .clk                (clk),
        .arstN              (arstN),
        .hostLoad           (hostLoad),
        .hostDone           (hostDone),
        .coreReq            (coreReq),
        .readResp           (readResp),
        .writeResp          (writeResp),
        .nextMemReadSerial  (nextMemReadSerial),
        .nextMemWriteSerial (nextMemWriteSerial),
        .programLoaded      (programLoaded),
        .rstStart           (rstStart)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    function automatic MemoryEntryDataPath expectedRead(AddrPath addr);
        return model[addr];
    endfunction

    function automatic MemoryEntryDataPath randomData();
        return {$urandom, $urandom};
    endfunction

    task automatic failRun(string msg);
        $display("%s", msg);
        $display("test failed");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic valueMismatch(string what, logic [63:0] expected, logic [63:0] actual);
        failRun($sformatf("[ERROR] %s: %s expected %0h actual %0h",
                          testName, what, expected, actual));
    endtask

    // Drive slot 1 ns after the rising edge, every request idle
    task automatic nextSlot();
        @(posedge clk);
        #1;
        hostLoad = '0;
        hostDone = 1'b0;
        coreReq  = '0;
    endtask

    task automatic expectRead(AddrPath addr);
        ExpectedRead item;
        assert (nextMemReadSerial == readSerial)
            else valueMismatch("read serial at issue", 64'(readSerial), 64'(nextMemReadSerial));
        item.due    = cycle + `MEM_READ_LATENCY;
        item.serial = readSerial;
        item.data   = expectedRead(addr);  // Entry as it is when the read is taken
        readExp.push_back(item);
        readSerial = MemAccessSerial'(readSerial + 1);
    endtask

    task automatic expectWrite(AddrPath addr, MemoryEntryDataPath data);
        ExpectedWrite item;
        assert (nextMemWriteSerial == writeSerial)
            else valueMismatch("write serial at issue", 64'(writeSerial), 64'(nextMemWriteSerial));
        item.due    = cycle + `MEM_WRITE_LATENCY;
        item.serial = writeSerial;
        writeExp.push_back(item);
        model[addr] = data;
        writeSerial = MemWriteSerial'(writeSerial + 1);
    endtask

    task automatic coreRead(AddrPath addr);
        coreReq.re   = 1'b1;
        coreReq.addr = addr;
        expectRead(addr);
    endtask

    task automatic coreWrite(AddrPath addr, MemoryEntryDataPath data);
        coreReq.we        = 1'b1;
        coreReq.addr      = addr;
        coreReq.writeData = data;
        expectWrite(addr, data);
    endtask

    task automatic waitDrain();
        nextSlot();
        while (readExp.size() != 0 || writeExp.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk);
    endtask

    // Outputs are compared at the falling edge, half a cycle after they change
    always @(negedge clk) begin : compareResponses
        ExpectedRead  rd;
        ExpectedWrite wr;
        if (rstStart) begin
            rstPulses = rstPulses + 1;
        end
        if (readResp.valid) begin
            assert (readExp.size() != 0)
                else failRun($sformatf("%s: read response with no read outstanding", testName));
            rd = readExp.pop_front();
            assert (rd.due == cycle) else valueMismatch("read cycle", 64'(rd.due), 64'(cycle));
            assert (readResp.serial == rd.serial)
                else valueMismatch("read serial", 64'(rd.serial), 64'(readResp.serial));
            assert (readResp.data == rd.data)
                else valueMismatch("read data", rd.data, readResp.data);
        end
        assert (readExp.size() == 0 || readExp[0].due > cycle)
            else failRun($sformatf("%s: read response missing at cycle %0d", testName, cycle));
        if (writeResp.valid) begin
            assert (writeExp.size() != 0)
                else failRun($sformatf("%s: write response with no write outstanding", testName));
            wr = writeExp.pop_front();
            assert (wr.due == cycle) else valueMismatch("write cycle", 64'(wr.due), 64'(cycle));
            assert (writeResp.serial == wr.serial)
                else valueMismatch("write serial", 64'(wr.serial), 64'(writeResp.serial));
        end
        assert (writeExp.size() == 0 || writeExp[0].due > cycle)
            else failRun($sformatf("%s: write response missing at cycle %0d", testName, cycle));
    end

    initial begin : watchdog
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        failRun("watchdog: the run did not finish in the expected time");
    end

    initial begin : stimulus
        AddrPath addr;
        AddrPath hostAddrs [$];
        int      releaseCycle;

        void'($urandom(32'h4b79f450));
        arstN    = 1'b0;
        hostLoad = '0;
        hostDone = 1'b0;
        coreReq  = '0;

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        arstN        = 1'b1;
        releaseCycle = cycle;
        repeat (`RST_HOLD_CYCLES + 4) begin
            @(negedge clk);
            assert (rstStart == (cycle == releaseCycle + `RST_HOLD_CYCLES))
                else valueMismatch("rstStart", 64'(cycle == releaseCycle + `RST_HOLD_CYCLES),
                                   64'(rstStart));
            assert (!programLoaded && !readResp.valid && !writeResp.valid)
                else failRun("reset: an output went high before loading");
        end

        // Core owns nothing yet, so none of these may respond
        testName = "core before load";
        repeat (EARLY_OPS) begin
            nextSlot();
            coreReq.addr = AddrPath'($urandom);
            if ($urandom_range(1) == 0) begin
                coreReq.re = 1'b1;
            end else begin
                coreReq.we        = 1'b1;
                coreReq.writeData = randomData();
            end
        end
        waitDrain();
        repeat (4) @(negedge clk);
        assert (!programLoaded) else failRun("core before load: programLoaded rose early");

        testName = "load";
        for (int a = 0; a < `MEM_ENTRY_NUM; a++) begin
            nextSlot();
            hostLoad.we   = 1'b1;
            hostLoad.addr = AddrPath'(a);
            hostLoad.data = randomData();
            expectWrite(hostLoad.addr, hostLoad.data);
        end
        nextSlot();
        hostDone = 1'b1;
        @(negedge clk);
        assert (!programLoaded) else failRun("load: programLoaded rose with hostDone");
        nextSlot();
        @(negedge clk);
        assert (programLoaded) else failRun("load: programLoaded did not rise after hostDone");
        waitDrain();

        testName = "readback";
        for (int a = 0; a < `MEM_ENTRY_NUM; a++) begin
            nextSlot();
            coreRead(AddrPath'(a));
        end
        waitDrain();

        testName = "random traffic";
        repeat (RANDOM_OPS) begin
            nextSlot();
            addr = AddrPath'($urandom_range(31));  // Narrow window, reads hit recent writes
            if ($urandom_range(1) == 0) begin
                coreRead(addr);
            end else begin
                coreWrite(addr, randomData());
            end
        end
        waitDrain();

        // Host beats after loading must leave the RAM alone
        testName = "host after load";
        repeat (HOST_BEATS) begin
            nextSlot();
            addr          = AddrPath'($urandom);
            hostLoad.we   = 1'b1;
            hostLoad.addr = addr;
            hostLoad.data = ~expectedRead(addr);
            hostAddrs.push_back(addr);
        end
        foreach (hostAddrs[i]) begin
            nextSlot();
            coreRead(hostAddrs[i]);
        end
        waitDrain();

        assert (rstPulses == 1)
            else valueMismatch("rstStart pulse count", 64'(1), 64'(rstPulses));
        $display("test passed");
        $finish;
    end

endmodule : MemSysTb

`default_nettype wire
